/* compile.f */
+incdir+tests
hw/padframe_pkg.sv
hw/pad_cfg_regs.sv
hw/pad_out_mux.sv
hw/pad_in_demux.sv
hw/periph_padframe.sv
tests/tb_periph_padframe.sv

/* Bender.yml */
package:
  name: periph_padframe

sources:
  - files:
      - hw/padframe_pkg.sv
      - hw/pad_cfg_regs.sv
      - hw/pad_out_mux.sv
      - hw/pad_in_demux.sv
      - hw/periph_padframe.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_periph_padframe.sv

/* tests/padframe_model.svh */
// Reference model of the pad select registers
// Expected bus responses and pad routing from the rule tables

`ifndef PADFRAME_MODEL_SVH
`define PADFRAME_MODEL_SVH

pad_sel_t model_sel [NUM_PADS];

function automatic void reset_model();
  for (int k = 0; k < NUM_PADS; k++) begin
    model_sel[k] = FUNC_GPIO;
  end
endfunction

// Pad k sits at byte address k*4, anything else is an error
task automatic apply_access(
  input  logic      write,
  input  reg_addr_t addr,
  input  reg_data_t wdata,
  input  reg_strb_t strb,
  output logic      exp_err,
  output reg_data_t exp_rdata
);
  int unsigned idx;
  exp_err   = (addr[1:0] != 2'b00) || (addr >= NUM_PADS * 4);
  exp_rdata = '0;
  idx       = 0;
  if (!exp_err) begin
    idx = addr / 4;
    if (!write) begin
      exp_rdata = {29'd0, model_sel[idx]};
    end else if (strb[0]) begin
      model_sel[idx] = wdata[2:0];
    end
  end
endtask

task automatic expect_pads(
  input  pad_vec_t gpio_out,
  input  pad_vec_t gpio_dir,
  input  logic     uart_tx,
  input  logic     sck,
  input  logic     mosi,
  input  logic     scl_oe,
  input  logic     sda_oe,
  output pad_vec_t exp_out,
  output pad_vec_t exp_oe
);
  pad_sel_t s;
  for (int k = 0; k < NUM_PADS; k++) begin
    s = model_sel[k];
    exp_out[k] = (s == FUNC_GPIO)     ? gpio_out[k] :
                 (s == FUNC_UART_TX)  ? uart_tx :
                 (s == FUNC_SPI_SCK)  ? sck :
                 (s == FUNC_SPI_MOSI) ? mosi : 1'b0;
    exp_oe[k]  = (s == FUNC_GPIO)    ? gpio_dir[k] :
                 (s == FUNC_I2C_SCL) ? scl_oe :
                 (s == FUNC_I2C_SDA) ? sda_oe :
                 (s == FUNC_UART_TX || s == FUNC_SPI_SCK || s == FUNC_SPI_MOSI);
  end
endtask

function automatic pad_vec_t expect_gpio_in(input pad_vec_t pin);
  pad_vec_t v;
  for (int k = 0; k < NUM_PADS; k++) begin
    v[k] = (model_sel[k] == FUNC_GPIO) ? pin[k] : 1'b0;
  end
  return v;
endfunction

// First matching pad from index 0 upward
function automatic logic expect_input(input pad_vec_t pin, input pad_sel_t func,
                                      input logic idle);
  for (int k = 0; k < NUM_PADS; k++) begin
    if (model_sel[k] == func) begin
      return pin[k];
    end
  end
  return idle;
endfunction

`endif

/* tests/tb_periph_padframe.sv */
// Testbench for the peripheral pad frame
// Random bus traffic and routing checks against a reference model

`timescale 1ns/100ps

module tb_periph_padframe;

  import padframe_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_write;
  reg_addr_t   reg_addr;
  reg_data_t   reg_wdata;
  reg_strb_t   reg_wstrb;
  logic        reg_ready;
  logic        reg_error;
  reg_data_t   reg_rdata;
  pad_vec_t    gpio_out;
  pad_vec_t    gpio_dir;
  pad_vec_t    gpio_in;
  logic        uart_tx;
  logic        spi_sck;
  logic        spi_mosi;
  logic        i2c_scl_oe;
  logic        i2c_sda_oe;
  logic        uart_rx;
  logic        spi_miso;
  logic        i2c_sda;
  pad_vec_t    pad_in;
  pad_vec_t    pad_out;
  pad_vec_t    pad_oe;
  logic [31:0] rng_state = 32'h51ba1fa6;

  `include "padframe_model.svh"

  periph_padframe dut0 (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .reg_valid_i  ( reg_valid  ),
    .reg_write_i  ( reg_write  ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .reg_wstrb_i  ( reg_wstrb  ),
    .reg_ready_o  ( reg_ready  ),
    .reg_error_o  ( reg_error  ),
    .reg_rdata_o  ( reg_rdata  ),
    .gpio_out_i   ( gpio_out   ),
    .gpio_dir_i   ( gpio_dir   ),
    .gpio_in_o    ( gpio_in    ),
    .uart_tx_i    ( uart_tx    ),
    .spi_sck_i    ( spi_sck    ),
    .spi_mosi_i   ( spi_mosi   ),
    .i2c_scl_oe_i ( i2c_scl_oe ),
    .i2c_sda_oe_i ( i2c_sda_oe ),
    .uart_rx_o    ( uart_rx    ),
    .spi_miso_o   ( spi_miso   ),
    .i2c_sda_o    ( i2c_sda    ),
    .pad_in_i     ( pad_in     ),
    .pad_out_o    ( pad_out    ),
    .pad_oe_o     ( pad_oe     )
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pads(input string name, input pad_vec_t exp, input pad_vec_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic drive_random_inputs();
    logic [31:0] r;
    r          = rand32();
    gpio_out   = r[7:0];
    gpio_dir   = r[15:8];
    pad_in     = r[23:16];
    uart_tx    = r[24];
    spi_sck    = r[25];
    spi_mosi   = r[26];
    i2c_scl_oe = r[27];
    i2c_sda_oe = r[28];
  endtask

  task automatic compare_routing(input string name);
    pad_vec_t exp_out;
    pad_vec_t exp_oe;
    expect_pads(gpio_out, gpio_dir, uart_tx, spi_sck, spi_mosi, i2c_scl_oe, i2c_sda_oe,
                exp_out, exp_oe);
    check_pads({name, " pad_out"}, exp_out, pad_out);
    check_pads({name, " pad_oe"}, exp_oe, pad_oe);
    check_pads({name, " gpio_in"}, expect_gpio_in(pad_in), gpio_in);
    check_bit({name, " uart_rx"}, expect_input(pad_in, FUNC_UART_RX, 1'b1), uart_rx);
    check_bit({name, " spi_miso"}, expect_input(pad_in, FUNC_SPI_MISO, 1'b0), spi_miso);
    check_bit({name, " i2c_sda"}, expect_input(pad_in, FUNC_I2C_SDA, 1'b1), i2c_sda);
  endtask

  // Called 2 ns after a rising edge, returns at the same phase
  task automatic reg_access(input string name, input logic write, input reg_addr_t addr,
                            input reg_data_t wdata, input reg_strb_t strb);
    logic      exp_err;
    reg_data_t exp_rdata;
    int        cycles;
    apply_access(write, addr, wdata, strb, exp_err, exp_rdata);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    reg_wstrb = strb;
    cycles    = 0;
    #1;
    check_bit({name, " early ready"}, 1'b0, reg_ready);
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!reg_ready && cycles < 10);
    if (!reg_ready) begin
      $display("Timeout in %s: the DUT gave no ready within 10 cycles", name);
      abort_run();
    end
    check_data({name, " latency"}, reg_data_t'(1), reg_data_t'(cycles));
    check_bit({name, " error"}, exp_err, reg_error);
    if (!write || exp_err) begin
      check_data({name, " rdata"}, exp_rdata, reg_rdata);
    end
    // New select already drives the pads in the ready cycle
    compare_routing({name, " ready cycle"});
    // Valid stays high through the ready and blocked cycles
    @(posedge clk);
    #1;
    check_bit({name, " ready drop"}, 1'b0, reg_ready);
    @(posedge clk);
    #1;
    check_bit({name, " blocked"}, 1'b0, reg_ready);
    #1;
    reg_valid = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    reg_addr_t   addr;
    pad_sel_t    code;
    clk        = 1'b0;
    rst_n      = 1'b0;
    reg_valid  = 1'b0;
    reg_write  = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    reg_wstrb  = '0;
    gpio_out   = '0;
    gpio_dir   = '0;
    uart_tx    = 1'b0;
    spi_sck    = 1'b0;
    spi_mosi   = 1'b0;
    i2c_scl_oe = 1'b0;
    i2c_sda_oe = 1'b0;
    pad_in     = '0;
    reset_model();

    repeat (2) begin
      @(posedge clk);
      #1;
      check_bit("reset ready", 1'b0, reg_ready);
      check_bit("reset error", 1'b0, reg_error);
    end
    #1;
    rst_n = 1'b1;
    drive_random_inputs();
    @(negedge clk);
    check_bit("post reset ready", 1'b0, reg_ready);
    check_bit("post reset error", 1'b0, reg_error);
    check_data("post reset rdata", '0, reg_rdata);
    check_pads("reset pad_out", gpio_out, pad_out);
    check_pads("reset pad_oe", gpio_dir, pad_oe);
    @(posedge clk);
    #2;
    for (int k = 0; k < NUM_PADS; k++) begin
      reg_access("reset read", 1'b0, reg_addr_t'(k * 4), '0, 4'hf);
    end

    // Register map with mapped, unaligned and out of range addresses
    repeat (80) begin
      r    = rand32();
      addr = {27'd0, r[4:2], 2'b00};
      if (r[1:0] == 2'd2) begin
        addr = addr + 1 + (r[6:5] % 3);
      end else if (r[1:0] == 2'd3) begin
        addr = rand32() | 32'h20;
      end
      reg_access("regmap", r[7], addr, rand32(), r[11:8]);
      compare_routing("regmap");
    end

    // Odd rounds crowd the input functions to force duplicates
    for (int round = 0; round < 20; round++) begin
      for (int k = 0; k < NUM_PADS; k++) begin
        r    = rand32();
        code = r[2:0];
        if (round % 2 == 1) begin
          case (r[1:0])
            2'd0: code = FUNC_GPIO;
            2'd1: code = FUNC_UART_RX;
            2'd2: code = FUNC_SPI_MISO;
            default: code = FUNC_I2C_SDA;
          endcase
        end
        reg_access("config", 1'b1, reg_addr_t'(k * 4), {r[31:8], 5'd0, code},
                   {r[7:5], 1'b1});
      end
      repeat (6) begin
        drive_random_inputs();
        @(negedge clk);
        compare_routing("routing");
        @(posedge clk);
        #2;
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* hw/periph_padframe.sv */
// Peripheral pad frame top level
// Config registers, output mux and input demux

`timescale 1ns/100ps

module periph_padframe (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  padframe_pkg::reg_addr_t reg_addr_i,
  input  padframe_pkg::reg_data_t reg_wdata_i,
  input  padframe_pkg::reg_strb_t reg_wstrb_i,
  output logic                    reg_ready_o,
  output logic                    reg_error_o,
  output padframe_pkg::reg_data_t reg_rdata_o,
  input  padframe_pkg::pad_vec_t  gpio_out_i,
  input  padframe_pkg::pad_vec_t  gpio_dir_i,
  output padframe_pkg::pad_vec_t  gpio_in_o,
  input  logic                    uart_tx_i,
  input  logic                    spi_sck_i,
  input  logic                    spi_mosi_i,
  input  logic                    i2c_scl_oe_i,
  input  logic                    i2c_sda_oe_i,
  output logic                    uart_rx_o,
  output logic                    spi_miso_o,
  output logic                    i2c_sda_o,
  input  padframe_pkg::pad_vec_t  pad_in_i,
  output padframe_pkg::pad_vec_t  pad_out_o,
  output padframe_pkg::pad_vec_t  pad_oe_o
);

  import padframe_pkg::*;

  pad_sel_arr_t pad_sel;

  pad_cfg_regs i_pad_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .reg_valid_i ( reg_valid_i ),
    .reg_write_i ( reg_write_i ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_wstrb_i ( reg_wstrb_i ),
    .reg_ready_o ( reg_ready_o ),
    .reg_error_o ( reg_error_o ),
    .reg_rdata_o ( reg_rdata_o ),
    .pad_sel_o   ( pad_sel     )
  );

  pad_out_mux i_pad_out_mux (
    .pad_sel_i    ( pad_sel      ),
    .gpio_out_i   ( gpio_out_i   ),
    .gpio_dir_i   ( gpio_dir_i   ),
    .uart_tx_i    ( uart_tx_i    ),
    .spi_sck_i    ( spi_sck_i    ),
    .spi_mosi_i   ( spi_mosi_i   ),
    .i2c_scl_oe_i ( i2c_scl_oe_i ),
    .i2c_sda_oe_i ( i2c_sda_oe_i ),
    .pad_out_o    ( pad_out_o    ),
    .pad_oe_o     ( pad_oe_o     )
  );

  pad_in_demux i_pad_in_demux (
    .pad_sel_i  ( pad_sel    ),
    .pad_in_i   ( pad_in_i   ),
    .gpio_in_o  ( gpio_in_o  ),
    .uart_rx_o  ( uart_rx_o  ),
    .spi_miso_o ( spi_miso_o ),
    .i2c_sda_o  ( i2c_sda_o  )
  );

endmodule

/* hw/pad_in_demux.sv */
// Pad input routing back to GPIO and peripheral inputs
// Lowest matching pad wins, idle level when no pad matches

`timescale 1ns/100ps

module pad_in_demux (
  input  padframe_pkg::pad_sel_arr_t pad_sel_i,
  input  padframe_pkg::pad_vec_t     pad_in_i,
  output padframe_pkg::pad_vec_t     gpio_in_o,
  output logic                       uart_rx_o,
  output logic                       spi_miso_o,
  output logic                       i2c_sda_o
);

  import padframe_pkg::*;

  // Scan from the top so the lowest index is applied last
  function automatic logic route_in(
    input pad_sel_arr_t sel,
    input pad_vec_t     pin,
    input pad_sel_t     func,
    input logic         idle
  );
    logic val;
    val = idle;
    for (int k = NUM_PADS - 1; k >= 0; k--) begin
      if (sel[k] == func) begin
        val = pin[k];
      end
    end
    return val;
  endfunction

  always_comb begin
    for (int k = 0; k < NUM_PADS; k++) begin
      gpio_in_o[k] = (pad_sel_i[k] == FUNC_GPIO) & pad_in_i[k];
    end
  end

  // UART and I2C lines idle high
  assign uart_rx_o  = route_in(pad_sel_i, pad_in_i, FUNC_UART_RX, 1'b1);
  assign spi_miso_o = route_in(pad_sel_i, pad_in_i, FUNC_SPI_MISO, 1'b0);
  assign i2c_sda_o  = route_in(pad_sel_i, pad_in_i, FUNC_I2C_SDA, 1'b1);

endmodule

/* hw/pad_out_mux.sv */
// Pad output value and output enable selection
// GPIO or peripheral source per pad, chosen by its function code

`timescale 1ns/100ps

module pad_out_mux (
  input  padframe_pkg::pad_sel_arr_t pad_sel_i,
  input  padframe_pkg::pad_vec_t     gpio_out_i,
  input  padframe_pkg::pad_vec_t     gpio_dir_i,
  input  logic                       uart_tx_i,
  input  logic                       spi_sck_i,
  input  logic                       spi_mosi_i,
  input  logic                       i2c_scl_oe_i,
  input  logic                       i2c_sda_oe_i,
  output padframe_pkg::pad_vec_t     pad_out_o,
  output padframe_pkg::pad_vec_t     pad_oe_o
);

  import padframe_pkg::*;

  always_comb begin
    pad_out_o = '0;
    pad_oe_o  = '0;
    for (int k = 0; k < NUM_PADS; k++) begin
      case (pad_sel_i[k])
        FUNC_GPIO: begin
          pad_out_o[k] = gpio_out_i[k];
          pad_oe_o[k]  = gpio_dir_i[k];
        end
        FUNC_UART_TX: begin
          pad_out_o[k] = uart_tx_i;
          pad_oe_o[k]  = 1'b1;
        end
        FUNC_SPI_SCK: begin
          pad_out_o[k] = spi_sck_i;
          pad_oe_o[k]  = 1'b1;
        end
        FUNC_SPI_MOSI: begin
          pad_out_o[k] = spi_mosi_i;
          pad_oe_o[k]  = 1'b1;
        end
        // Input functions leave the pad undriven
        FUNC_UART_RX, FUNC_SPI_MISO: begin
          pad_out_o[k] = 1'b0;
          pad_oe_o[k]  = 1'b0;
        end
        // Open drain, the enable pulls the line low
        FUNC_I2C_SCL: begin
          pad_out_o[k] = 1'b0;
          pad_oe_o[k]  = i2c_scl_oe_i;
        end
        FUNC_I2C_SDA: begin
          pad_out_o[k] = 1'b0;
          pad_oe_o[k]  = i2c_sda_oe_i;
        end
        default: begin
          pad_out_o[k] = 1'b0;
          pad_oe_o[k]  = 1'b0;
        end
      endcase
    end
  end

endmodule

/* hw/pad_cfg_regs.sv */
// Register bus slave for the per-pad function selects
// Fixed one-cycle response, one idle cycle after each access

`timescale 1ns/100ps

module pad_cfg_regs (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  padframe_pkg::reg_addr_t    reg_addr_i,
  input  padframe_pkg::reg_data_t    reg_wdata_i,
  input  padframe_pkg::reg_strb_t    reg_wstrb_i,
  output logic                       reg_ready_o,
  output logic                       reg_error_o,
  output padframe_pkg::reg_data_t    reg_rdata_o,
  output padframe_pkg::pad_sel_arr_t pad_sel_o
);

  import padframe_pkg::*;

  logic         ack_q;
  logic         hold_q;
  logic         err_q;
  reg_data_t    rdata_q;
  pad_sel_arr_t pad_sel_q;

  logic         accept;
  logic         addr_hit;
  reg_addr_t    pad_offset;
  int unsigned  pad_idx;

  // Blocked while ready is high and for one cycle after
  assign accept = reg_valid_i & ~ack_q & ~hold_q;

  always_comb begin
    pad_offset = reg_addr_i - PAD_SEL_BASE;
    addr_hit   = (pad_offset < NUM_PADS * PAD_SEL_STRIDE) &&
                 (pad_offset % PAD_SEL_STRIDE == 0);
    pad_idx    = pad_offset / PAD_SEL_STRIDE;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      hold_q    <= 1'b0;
      err_q     <= 1'b0;
      rdata_q   <= '0;
      pad_sel_q <= {NUM_PADS{FUNC_GPIO}};
    end else begin
      ack_q  <= accept;
      hold_q <= ack_q;
      err_q  <= accept & ~addr_hit;

      if (accept && addr_hit && !reg_write_i) begin
        rdata_q <= reg_data_t'(pad_sel_q[pad_idx]);
      end else begin
        rdata_q <= '0;
      end

      // Only byte 0 carries the select field
      if (accept && addr_hit && reg_write_i && reg_wstrb_i[0]) begin
        pad_sel_q[pad_idx] <= reg_wdata_i[SEL_W-1:0];
      end
    end
  end

  assign reg_ready_o = ack_q;
  assign reg_error_o = err_q;
  assign reg_rdata_o = rdata_q;
  assign pad_sel_o   = pad_sel_q;

endmodule

/* hw/padframe_pkg.sv */
// Shared constants and types for the peripheral pad frame
// Widths, pad count, function codes and register map

package padframe_pkg;

  // Bus and pad dimensions
  localparam int unsigned NUM_PADS = 8;
  localparam int unsigned REG_AW   = 32;
  localparam int unsigned REG_DW   = 32;
  localparam int unsigned SEL_W    = 3;

  typedef logic [REG_AW-1:0]   reg_addr_t;
  typedef logic [REG_DW-1:0]   reg_data_t;
  typedef logic [REG_DW/8-1:0] reg_strb_t;

  typedef logic [NUM_PADS-1:0] pad_vec_t;
  typedef logic [SEL_W-1:0]    pad_sel_t;

  // Index k holds the select of pad k
  typedef pad_sel_t [NUM_PADS-1:0] pad_sel_arr_t;

  // Per-pad function codes
  localparam pad_sel_t FUNC_GPIO     = 3'd0;
  localparam pad_sel_t FUNC_UART_TX  = 3'd1;
  localparam pad_sel_t FUNC_UART_RX  = 3'd2;
  localparam pad_sel_t FUNC_SPI_SCK  = 3'd3;
  localparam pad_sel_t FUNC_SPI_MOSI = 3'd4;
  localparam pad_sel_t FUNC_SPI_MISO = 3'd5;
  localparam pad_sel_t FUNC_I2C_SCL  = 3'd6;
  localparam pad_sel_t FUNC_I2C_SDA  = 3'd7;

  // One word per pad, starting at the base
  localparam reg_addr_t   PAD_SEL_BASE   = '0;
  localparam int unsigned PAD_SEL_STRIDE = 4;

endpackage
